/* logic/hwloop_cfg_pkg.sv */
/*
  hardware-loop sizes and register map
  - loop count and index width
  - address, data and Wishbone word address widths
  - field codes inside one loop's register slot
*/
package hwloop_cfg_pkg;

  // two loops, loop 0 is the inner one
  localparam int N_LOOPS   = 2;
  localparam int LOOP_ID_W = 1;

  // fetch addresses and register contents share one width
  localparam int ADDR_W    = 32;

  // word address is loop index * 4 + field code
  localparam int WB_ADR_W  = 4;
  localparam int FIELD_W   = 2;

  // field code 3 is reserved, reads zero and drops writes
  localparam logic [FIELD_W-1:0] FIELD_START = 2'd0;
  localparam logic [FIELD_W-1:0] FIELD_END   = 2'd1;
  localparam logic [FIELD_W-1:0] FIELD_COUNT = 2'd2;

endpackage

/* logic/hwloop_types_pkg.sv */
/*
  bundles passed between the hardware-loop blocks
  - Wishbone classic request and response
  - register write port, per-loop state and the full loop set
  - fetch request and jump response
*/
package hwloop_types_pkg;

  // master to slave
  typedef struct packed {
    logic                                cyc;
    logic                                stb;
    logic                                we;
    logic [hwloop_cfg_pkg::WB_ADR_W-1:0] adr;
    logic [hwloop_cfg_pkg::ADDR_W-1:0]   dat;
  } wb_req_t;

  // slave to master, both fields registered
  typedef struct packed {
    logic                              ack;
    logic [hwloop_cfg_pkg::ADDR_W-1:0] dat;
  } wb_rsp_t;

  // one write per cycle, at most one enable set
  typedef struct packed {
    logic                                 we_start;
    logic                                 we_end;
    logic                                 we_count;
    logic [hwloop_cfg_pkg::LOOP_ID_W-1:0] id;
    logic [hwloop_cfg_pkg::ADDR_W-1:0]    data;
  } hwlp_wr_t;

  typedef struct packed {
    logic [hwloop_cfg_pkg::ADDR_W-1:0] start_addr;
    logic [hwloop_cfg_pkg::ADDR_W-1:0] end_addr;
    logic [hwloop_cfg_pkg::ADDR_W-1:0] count;
  } hwlp_loop_t;

  typedef hwlp_loop_t [hwloop_cfg_pkg::N_LOOPS-1:0] hwlp_set_t;

  typedef struct packed {
    logic                              valid;
    logic [hwloop_cfg_pkg::ADDR_W-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic                              jump;
    logic [hwloop_cfg_pkg::ADDR_W-1:0] target;
  } fetch_rsp_t;

endpackage

/* logic/hwloop_regs.sv */
/*
  hardware-loop register file
  - start, end and counter register per loop
  - bus writes from the Wishbone slave
  - counter decrement requested by the loop controller
*/
`timescale 1ns/1ns

module hwloop_regs (
  input  logic                                  clk,
  input  logic                                  rst_n,
  // write port from the bus slave
  input  hwloop_types_pkg::hwlp_wr_t            wr_i,
  // decrement request from the controller
  input  logic [hwloop_cfg_pkg::N_LOOPS-1:0]    dec_i,
  input  logic                                  dec_valid_i,
  // current state of every loop
  output hwloop_types_pkg::hwlp_set_t           loops_o
);

  hwloop_types_pkg::hwlp_set_t loops_q;

  assign loops_o = loops_q;

  //////////////////////////////////////////////////
  // one register slot per loop
  //////////////////////////////////////////////////
  for (genvar l = 0; l < hwloop_cfg_pkg::N_LOOPS; l++)
  begin : g_loop
    logic sel;
    logic dec;

    // this slot is the target of the bus write
    assign sel = (wr_i.id == hwloop_cfg_pkg::LOOP_ID_W'(l));
    // controller serviced this loop in the current cycle
    assign dec = dec_valid_i & dec_i[l];

    // start address
    always_ff @(posedge clk or negedge rst_n)
    begin
      if (!rst_n)
      begin
        loops_q[l].start_addr <= '0;
      end
      else if (wr_i.we_start && sel)
      begin
        loops_q[l].start_addr <= wr_i.data;
      end
    end

    // end address
    always_ff @(posedge clk or negedge rst_n)
    begin
      if (!rst_n)
      begin
        loops_q[l].end_addr <= '0;
      end
      else if (wr_i.we_end && sel)
      begin
        loops_q[l].end_addr <= wr_i.data;
      end
    end

    // counter, a bus write beats a decrement in the same cycle
    always_ff @(posedge clk or negedge rst_n)
    begin
      if (!rst_n)
      begin
        loops_q[l].count <= '0;
      end
      else if (wr_i.we_count && sel)
      begin
        loops_q[l].count <= wr_i.data;
      end
      else if (dec)
      begin
        loops_q[l].count <= loops_q[l].count - hwloop_cfg_pkg::ADDR_W'(1);
      end
    end
  end

endmodule

/* logic/hwloop_wb_slave.sv */
/*
  Wishbone classic slave for the loop registers
  - ack bit, one ack per request, two cycles per access
  - address split into loop slot and field code
  - write enables towards the register file
  - registered read data, reserved field reads zero
*/
`timescale 1ns/1ns

module hwloop_wb_slave (
  input  logic                         clk,
  input  logic                         rst_n,
  input  hwloop_types_pkg::wb_req_t    wb_req_i,
  output hwloop_types_pkg::wb_rsp_t    wb_rsp_o,
  // register state for read-back
  input  hwloop_types_pkg::hwlp_set_t  loops_i,
  // write port into the register file
  output hwloop_types_pkg::hwlp_wr_t   wr_o
);

  localparam int SLOT_W = hwloop_cfg_pkg::WB_ADR_W - hwloop_cfg_pkg::FIELD_W;

  logic                                 req;
  logic                                 access;
  logic                                 ack_q;
  logic [hwloop_cfg_pkg::ADDR_W-1:0]    rdat_q;
  logic [hwloop_cfg_pkg::ADDR_W-1:0]    rd_mux;
  logic [SLOT_W-1:0]                    slot;
  logic                                 in_range;
  logic [hwloop_cfg_pkg::FIELD_W-1:0]   field;
  logic [hwloop_cfg_pkg::LOOP_ID_W-1:0] id;

  //////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////
  assign req    = wb_req_i.cyc & wb_req_i.stb;
  // no access in the ack cycle, a held request restarts afterwards
  assign access = req & ~ack_q;

  // address decode
  assign field    = wb_req_i.adr[hwloop_cfg_pkg::FIELD_W-1:0];
  assign slot     = wb_req_i.adr[hwloop_cfg_pkg::WB_ADR_W-1:hwloop_cfg_pkg::FIELD_W];
  // slots past the last loop behave like the reserved field
  assign in_range = (slot < hwloop_cfg_pkg::N_LOOPS);
  assign id       = slot[hwloop_cfg_pkg::LOOP_ID_W-1:0];

  // read mux over the addressed slot
  always_comb
  begin
    rd_mux = '0;
    if (in_range)
    begin
      case (field)
        hwloop_cfg_pkg::FIELD_START: rd_mux = loops_i[id].start_addr;
        hwloop_cfg_pkg::FIELD_END:   rd_mux = loops_i[id].end_addr;
        hwloop_cfg_pkg::FIELD_COUNT: rd_mux = loops_i[id].count;
        default:                     rd_mux = '0;
      endcase
    end
  end

  // write strobe lands on the edge that raises ack
  always_comb
  begin
    wr_o      = '0;
    wr_o.id   = id;
    wr_o.data = wb_req_i.dat;
    if (access && wb_req_i.we && in_range)
    begin
      wr_o.we_start = (field == hwloop_cfg_pkg::FIELD_START);
      wr_o.we_end   = (field == hwloop_cfg_pkg::FIELD_END);
      wr_o.we_count = (field == hwloop_cfg_pkg::FIELD_COUNT);
    end
  end

  //////////////////////////////////////////////////
  // ack and read data registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ack_q  <= 1'b0;
      rdat_q <= '0;
    end
    else
    begin
      ack_q <= access;
      // writes return zero on the data lines
      if (access)
      begin
        rdat_q <= wb_req_i.we ? '0 : rd_mux;
      end
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdat_q;

endmodule

/* logic/hwloop_controller.sv */
/*
  hardware-loop controller, purely combinational
  - end-address match against every active loop
  - lowest loop index wins
  - jump target and one decrement request
*/
`timescale 1ns/1ns

module hwloop_controller (
  input  hwloop_types_pkg::fetch_req_t        fetch_i,
  input  hwloop_types_pkg::hwlp_set_t         loops_i,
  output hwloop_types_pkg::fetch_rsp_t        fetch_o,
  output logic [hwloop_cfg_pkg::N_LOOPS-1:0]  dec_o,
  output logic                                dec_valid_o
);

  logic [hwloop_cfg_pkg::N_LOOPS-1:0]   hit;
  logic                                 found;
  logic [hwloop_cfg_pkg::LOOP_ID_W-1:0] win;

  //////////////////////////////////////////////////
  // per-loop match
  //////////////////////////////////////////////////
  for (genvar l = 0; l < hwloop_cfg_pkg::N_LOOPS; l++)
  begin : g_hit
    // active loop, valid fetch sitting on its last instruction
    assign hit[l] = fetch_i.valid &&
                    (loops_i[l].count != '0) &&
                    (loops_i[l].end_addr == fetch_i.addr);
  end

  // priority pick, scan downwards so the inner loop overrides
  always_comb
  begin
    found = 1'b0;
    win   = '0;
    for (int i = hwloop_cfg_pkg::N_LOOPS - 1; i >= 0; i--)
    begin
      if (hit[i])
      begin
        found = 1'b1;
        win   = hwloop_cfg_pkg::LOOP_ID_W'(i);
      end
    end
  end

  //////////////////////////////////////////////////
  // response and decrement
  //////////////////////////////////////////////////
  always_comb
  begin
    dec_o          = '0;
    fetch_o.jump   = 1'b0;
    fetch_o.target = '0;
    if (found)
    begin
      // only the winning loop counts down
      dec_o[win] = 1'b1;
      // last pass (count one) falls through without a jump
      if (loops_i[win].count > hwloop_cfg_pkg::ADDR_W'(1))
      begin
        fetch_o.jump   = 1'b1;
        fetch_o.target = loops_i[win].start_addr;
      end
    end
  end

  assign dec_valid_o = found;

endmodule

/* logic/hwloop_unit.sv */
/*
  hardware-loop unit top level
  - Wishbone classic configuration port
  - loop register file
  - fetch-side loop controller
*/
`timescale 1ns/1ns

module hwloop_unit (
  input  logic                          clk,
  input  logic                          rst_n,
  // configuration bus
  input  hwloop_types_pkg::wb_req_t     wb_req_i,
  output hwloop_types_pkg::wb_rsp_t     wb_rsp_o,
  // fetch stage
  input  hwloop_types_pkg::fetch_req_t  fetch_i,
  output hwloop_types_pkg::fetch_rsp_t  fetch_o
);

  hwloop_types_pkg::hwlp_wr_t         wr;
  hwloop_types_pkg::hwlp_set_t        loops;
  logic [hwloop_cfg_pkg::N_LOOPS-1:0] dec;
  logic                               dec_valid;

  // bus side, writes and read-back
  hwloop_wb_slave u_wb_slave (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_req_i (wb_req_i),
    .wb_rsp_o (wb_rsp_o),
    .loops_i  (loops),
    .wr_o     (wr)
  );

  // loop state
  hwloop_regs u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_i        (wr),
    .dec_i       (dec),
    .dec_valid_i (dec_valid),
    .loops_o     (loops)
  );

  // zero-latency jump decision
  hwloop_controller u_controller (
    .fetch_i     (fetch_i),
    .loops_i     (loops),
    .fetch_o     (fetch_o),
    .dec_o       (dec),
    .dec_valid_o (dec_valid)
  );

endmodule

/* verif/hwloop_unit_properties.sv */
/*
  concurrent checks for the hardware-loop unit
  - one decrement at a time from the controller
  - single-cycle ack on the Wishbone slave
  - ack only after a request
  - count of failed checks for the testbench
*/
`timescale 1ns/1ns

module hwloop_unit_properties (
  input logic                               clk,
  input logic                               rst_n,
  input logic [hwloop_cfg_pkg::N_LOOPS-1:0] dec_i,
  input logic                               dec_valid_i,
  input logic                               cyc_i,
  input logic                               stb_i,
  input logic                               ack_i
);

  // failed checks that the testbench polls
  int unsigned fail_count = 0;

  // controller services a single loop per fetch
  a_dec_single: assert property (@(posedge clk) disable iff (!rst_n)
    dec_valid_i |-> $onehot0(dec_i))
    else
    begin
      fail_count = fail_count + 1;
      $error("more than one loop decremented");
    end

  // ack is a one-cycle pulse
  a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    ack_i |=> !ack_i)
    else
    begin
      fail_count = fail_count + 1;
      $error("ack high for two cycles");
    end

  // no ack without a request in the cycle before
  a_ack_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack_i) |-> $past(cyc_i && stb_i))
    else
    begin
      fail_count = fail_count + 1;
      $error("ack raised without a request");
    end

endmodule

// controller and slave signals meet in the top level
bind hwloop_unit hwloop_unit_properties u_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .dec_i       (dec),
  .dec_valid_i (dec_valid),
  .cyc_i       (wb_req_i.cyc),
  .stb_i       (wb_req_i.stb),
  .ack_i       (wb_rsp_o.ack)
);

/* verif/hwloop_unit_tb.sv */
/*
  testbench for the hardware-loop unit
  - clock, reset, LFSR stimulus source and cycle limit
  - reference model of the loop rules and a fetch compare process
  - Wishbone read and write tasks, compare tasks
  - reset, register, single loop, nested, collision and inactive tests
*/
`timescale 1ns/1ns

module hwloop_unit_tb;

  // all tests together stay well below 1000 cycles
  localparam int MAX_CYCLES = 4000;

  logic                         clk;
  logic                         rst_n;
  hwloop_types_pkg::wb_req_t    wb_req;
  hwloop_types_pkg::wb_rsp_t    wb_rsp;
  hwloop_types_pkg::fetch_req_t fetch_req;
  hwloop_types_pkg::fetch_rsp_t fetch_rsp;

  // model state as of the current cycle
  hwloop_types_pkg::hwlp_set_t  model_loops;
  hwloop_types_pkg::hwlp_set_t  model_next;
  hwloop_types_pkg::fetch_rsp_t exp_rsp;
  hwloop_types_pkg::fetch_rsp_t exp_last;
  // bus write landing on the next rising edge
  hwloop_types_pkg::hwlp_wr_t   pend_wr;
  logic [31:0]                  jump_count;
  logic [31:0]                  lfsr_state;
  int                           cycles;

  hwloop_unit DUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp),
    .fetch_i  (fetch_req),
    .fetch_o  (fetch_rsp)
  );

  always #10 clk = ~clk;

  //////////////////////////////////////////////////
  // failure reporting and compares
  //////////////////////////////////////////////////
  task automatic report_failure();
    $display("** FAIL **");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_word(input logic [hwloop_cfg_pkg::ADDR_W-1:0] got,
                            input logic [hwloop_cfg_pkg::ADDR_W-1:0] exp,
                            input string what);
    if (got !== exp)
    begin
      $display("ERR %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
      report_failure();
    end
  endtask

  task automatic check_fetch(input hwloop_types_pkg::fetch_rsp_t got,
                             input hwloop_types_pkg::fetch_rsp_t exp,
                             input logic [31:0] addr);
    // target only matters when a jump is taken
    if (got.jump !== exp.jump || (exp.jump && got.target !== exp.target))
    begin
      $display("ERR %0t: fetch 0x%08h gave jump %0b to 0x%08h, expected %0b to 0x%08h",
               $time, addr, got.jump, got.target, exp.jump, exp.target);
      report_failure();
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus source
  //////////////////////////////////////////////////
  // fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  function automatic hwloop_types_pkg::fetch_rsp_t model_fetch(
    input  hwloop_types_pkg::fetch_req_t f,
    input  hwloop_types_pkg::hwlp_set_t  cur,
    output hwloop_types_pkg::hwlp_set_t  nxt);
    hwloop_types_pkg::fetch_rsp_t r;
    logic                         taken;
    r     = '0;
    nxt   = cur;
    taken = 1'b0;
    // the lowest active loop ending here wins
    for (int i = 0; i < hwloop_cfg_pkg::N_LOOPS; i++)
    begin
      if (f.valid && !taken && cur[i].count != 0 && cur[i].end_addr == f.addr)
      begin
        taken        = 1'b1;
        nxt[i].count = cur[i].count - 1;
        if (cur[i].count > 1)
        begin
          r.jump   = 1'b1;
          r.target = cur[i].start_addr;
        end
      end
    end
    return r;
  endfunction

  // register value as software reads it
  function automatic logic [31:0] model_field(input int id, input logic [1:0] field);
    case (field)
      hwloop_cfg_pkg::FIELD_START: return model_loops[id].start_addr;
      hwloop_cfg_pkg::FIELD_END:   return model_loops[id].end_addr;
      hwloop_cfg_pkg::FIELD_COUNT: return model_loops[id].count;
      default:                     return '0;
    endcase
  endfunction

  // compare and advance the model on every rising edge
  always @(posedge clk)
  begin
    if (rst_n)
    begin
      exp_rsp = model_fetch(fetch_req, model_loops, model_next);
      if (fetch_req.valid)
      begin
        check_fetch(fetch_rsp, exp_rsp, fetch_req.addr);
        if (fetch_rsp.jump)
          jump_count = jump_count + 1;
      end
      // bus write on the same edge overrides the decrement
      if (pend_wr.we_start)
        model_next[pend_wr.id].start_addr = pend_wr.data;
      if (pend_wr.we_end)
        model_next[pend_wr.id].end_addr = pend_wr.data;
      if (pend_wr.we_count)
        model_next[pend_wr.id].count = pend_wr.data;
      pend_wr     = '0;
      model_loops = model_next;
      exp_last    = exp_rsp;
    end
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (DUT.u_props.fail_count != 0)
    begin
      $display("a bound assertion on the DUT failed");
      report_failure();
    end
    else if (cycles >= MAX_CYCLES)
    begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      report_failure();
    end
  end

  //////////////////////////////////////////////////
  // bus and fetch tasks
  //////////////////////////////////////////////////
  task automatic bus_access(input logic we, input int id, input logic [1:0] field,
                            input logic [31:0] wdat, output logic [31:0] rdat);
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = hwloop_cfg_pkg::WB_ADR_W'(id * 4 + field);
    wb_req.dat = wdat;
    if (we)
    begin
      // reserved field leaves every enable low
      pend_wr          = '0;
      pend_wr.id       = hwloop_cfg_pkg::LOOP_ID_W'(id);
      pend_wr.data     = wdat;
      pend_wr.we_start = (field == hwloop_cfg_pkg::FIELD_START);
      pend_wr.we_end   = (field == hwloop_cfg_pkg::FIELD_END);
      pend_wr.we_count = (field == hwloop_cfg_pkg::FIELD_COUNT);
    end
    @(negedge clk);
    // ack follows the request after exactly one rising edge
    if (wb_rsp.ack !== 1'b1)
    begin
      $display("ERR %0t: no ack in the cycle after the request", $time);
      report_failure();
    end
    rdat   = wb_rsp.dat;
    wb_req = '0;
  endtask

  task automatic wb_write(input int id, input logic [1:0] field, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, id, field, data, unused);
  endtask

  task automatic read_check(input int id, input logic [1:0] field, input logic [31:0] exp);
    logic [31:0] rd;
    bus_access(1'b0, id, field, '0, rd);
    check_word(rd, exp, $sformatf("loop %0d field %0d", id, field));
  endtask

  // sequential fetch that follows every predicted jump
  task automatic run_stream(input logic [31:0] first, input logic [31:0] stop,
                            input int max_steps);
    logic [31:0] pc;
    int          steps;
    pc    = first;
    steps = 0;
    @(negedge clk);
    while (pc != stop && steps < max_steps)
    begin
      fetch_req.valid = 1'b1;
      fetch_req.addr  = pc;
      @(negedge clk);
      pc    = exp_last.jump ? exp_last.target : pc + 4;
      steps = steps + 1;
    end
    fetch_req = '0;
    if (pc != stop)
    begin
      $display("fetch stream from 0x%08h never reached 0x%08h", first, stop);
      report_failure();
    end
  endtask

  // loop 1 wraps loop 0 and may end on the same word
  task automatic nested_case(input logic same_end);
    logic [31:0] s0;
    logic [31:0] e0;
    logic [31:0] s1;
    logic [31:0] e1;
    int          body;
    s1   = rand_bits(16) << 2;
    s0   = s1 + 4;
    body = 1 + rand_bits(2);
    e0   = s0 + 4 * (body - 1);
    e1   = same_end ? e0 : e0 + 4;
    wb_write(0, hwloop_cfg_pkg::FIELD_START, s0);
    wb_write(0, hwloop_cfg_pkg::FIELD_END, e0);
    wb_write(0, hwloop_cfg_pkg::FIELD_COUNT, 1 + rand_bits(2));
    wb_write(1, hwloop_cfg_pkg::FIELD_START, s1);
    wb_write(1, hwloop_cfg_pkg::FIELD_END, e1);
    wb_write(1, hwloop_cfg_pkg::FIELD_COUNT, 1 + rand_bits(2));
    run_stream(s1, e1 + 4, 200);
    read_check(0, hwloop_cfg_pkg::FIELD_COUNT, model_field(0, hwloop_cfg_pkg::FIELD_COUNT));
    read_check(1, hwloop_cfg_pkg::FIELD_COUNT, model_field(1, hwloop_cfg_pkg::FIELD_COUNT));
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  initial
  begin
    logic [31:0] s0;
    logic [31:0] e0;
    logic [31:0] cnt;
    logic [31:0] val;
    logic [1:0]  fld;
    int          id;
    int          body;
    clk         = 1'b0;
    rst_n       = 1'b0;
    wb_req      = '0;
    fetch_req   = '0;
    model_loops = '0;
    pend_wr     = '0;
    exp_last    = '0;
    jump_count  = '0;
    lfsr_state  = 32'd87792;
    cycles      = 0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    // reset values of every field including the reserved one
    for (int i = 0; i < hwloop_cfg_pkg::N_LOOPS; i++)
      for (int f = 0; f < 4; f++)
        read_check(i, 2'(f), '0);

    // random writes each followed by a read
    repeat (40)
    begin
      id  = rand_bits(1);
      fld = 2'(rand_bits(2));
      val = rand_bits(32);
      wb_write(id, fld, val);
      read_check(id, fld, model_field(id, fld));
    end

    // single loop with count 1..8 and a body of 1..4 words
    wb_write(1, hwloop_cfg_pkg::FIELD_COUNT, '0);
    s0   = rand_bits(16) << 2;
    body = 1 + rand_bits(2);
    cnt  = 1 + rand_bits(3);
    e0   = s0 + 4 * (body - 1);
    wb_write(0, hwloop_cfg_pkg::FIELD_START, s0);
    wb_write(0, hwloop_cfg_pkg::FIELD_END, e0);
    wb_write(0, hwloop_cfg_pkg::FIELD_COUNT, cnt);
    jump_count = '0;
    run_stream(s0, e0 + 4, 100);
    check_word(jump_count, cnt - 1, "loop 0 jump count");
    read_check(0, hwloop_cfg_pkg::FIELD_COUNT, '0);

    // nested loops with distinct then shared end addresses
    nested_case(1'b0);
    nested_case(1'b1);

    // counter write on the edge of a decrementing fetch
    wb_write(1, hwloop_cfg_pkg::FIELD_COUNT, '0);
    s0 = rand_bits(16) << 2;
    e0 = s0 + 8;
    wb_write(0, hwloop_cfg_pkg::FIELD_START, s0);
    wb_write(0, hwloop_cfg_pkg::FIELD_END, e0);
    wb_write(0, hwloop_cfg_pkg::FIELD_COUNT, 5);
    val = rand_bits(16);
    fork
      wb_write(0, hwloop_cfg_pkg::FIELD_COUNT, val);
      begin
        @(negedge clk);
        fetch_req.valid = 1'b1;
        fetch_req.addr  = e0;
        @(negedge clk);
        fetch_req = '0;
      end
    join
    read_check(0, hwloop_cfg_pkg::FIELD_COUNT, model_field(0, hwloop_cfg_pkg::FIELD_COUNT));

    // inactive loop sitting on its end address
    wb_write(0, hwloop_cfg_pkg::FIELD_COUNT, '0);
    jump_count = '0;
    repeat (4)
    begin
      @(negedge clk);
      fetch_req.valid = 1'b1;
      fetch_req.addr  = e0;
    end
    @(negedge clk);
    fetch_req = '0;
    check_word(jump_count, '0, "jumps on an inactive loop");
    read_check(0, hwloop_cfg_pkg::FIELD_COUNT, '0);

    if (DUT.u_props.fail_count != 0)
    begin
      $display("a bound assertion on the DUT failed");
      report_failure();
    end
    else
    begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

/* hwloop_unit.f */
logic/hwloop_cfg_pkg.sv
logic/hwloop_types_pkg.sv
logic/hwloop_regs.sv
logic/hwloop_wb_slave.sv
logic/hwloop_controller.sv
logic/hwloop_unit.sv
verif/hwloop_unit_properties.sv
verif/hwloop_unit_tb.sv

/* Bender.yml */
package:
  name: hwloop_unit

sources:
  - logic/hwloop_cfg_pkg.sv
  - logic/hwloop_types_pkg.sv
  - logic/hwloop_regs.sv
  - logic/hwloop_wb_slave.sv
  - logic/hwloop_controller.sv
  - logic/hwloop_unit.sv
  - target: test
    files:
      - verif/hwloop_unit_properties.sv
      - verif/hwloop_unit_tb.sv
